// File: design/mem_axil_cfg.svh
`ifndef MEM_AXIL_CFG_SVH
`define MEM_AXIL_CFG_SVH

// Address width on both the message side and the AXI-Lite side
`define MEM_AXIL_ADDR_W 32

// Message data and AXI-Lite data are the same width
`define MEM_AXIL_DATA_W 32

// Requester tag, echoed back untouched
`define MEM_AXIL_TAG_W 4

`endif

// File: design/mem_axil_pkg.sv
`include "mem_axil_cfg.svh"

package mem_axil_pkg;

  // Message kinds from the requester
  typedef enum logic [1:0]
  {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_type_e;

  // Access size in bytes, 8-byte accesses not supported
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } mem_size_e;

  // Forward header, reverse header is an exact echo of it
  typedef struct packed
  {
    mem_msg_type_e               msg_type;
    mem_size_e                   size;
    logic [`MEM_AXIL_ADDR_W-1:0] addr;
    logic [`MEM_AXIL_TAG_W-1:0]  tag;
  } mem_header_s;

endpackage

// File: design/axil_req_if.sv
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

// One AXI-Lite request handed from the bridge to the channel sequencer
interface axil_req_if;

  logic [`MEM_AXIL_ADDR_W-1:0]   addr;
  logic [`MEM_AXIL_DATA_W-1:0]   wdata;
  logic [`MEM_AXIL_DATA_W/8-1:0] wstrb;
  // High for a write, low for a read
  logic                          write;
  logic                          valid;
  logic                          ready;

  modport master
  (
    output addr,
    output wdata,
    output wstrb,
    output write,
    output valid,
    input  ready
  );

  modport slave
  (
    input  addr,
    input  wdata,
    input  wstrb,
    input  write,
    input  valid,
    output ready
  );

endinterface

// File: design/two_entry_fifo.sv
`timescale 1ns/1ps

module two_entry_fifo
#(
  parameter type T = logic [7:0]
)
(
  input  logic clk_i,
  input  logic rst_n_i,

  input  T     data_i,
  input  logic v_i,
  output logic ready_o,

  output T     data_o,
  output logic v_o,
  input  logic yumi_i
);

  T     slot_q [0:1];
  logic wr_ptr_q;
  logic rd_ptr_q;
  // Pointers equal means either empty or full, this bit tells which
  logic full_q;
  logic enq;
  logic deq;

  assign ready_o = ~full_q;
  assign v_o     = full_q | (wr_ptr_q != rd_ptr_q);
  assign data_o  = slot_q[rd_ptr_q];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
    end
    else
    begin
      if (enq)
        wr_ptr_q <= ~wr_ptr_q;
      if (deq)
        rd_ptr_q <= ~rd_ptr_q;
      // Simultaneous push and pop keeps the fill level
      if (enq && !deq)
        full_q <= (~wr_ptr_q == rd_ptr_q);
      else if (deq && !enq)
        full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      slot_q[wr_ptr_q] <= data_i;
  end

endmodule

// File: design/axil_txn_master.sv
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

// Single outstanding AXI-Lite transaction, result held until taken
module axil_txn_master
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  axil_req_if.slave                     req,

  output logic [`MEM_AXIL_DATA_W-1:0]   rdata_o,
  output logic                          rsp_v_o,
  input  logic                          rsp_ready_i,

  output logic [`MEM_AXIL_ADDR_W-1:0]   m_axil_awaddr_o,
  output logic [2:0]                    m_axil_awprot_o,
  output logic                          m_axil_awvalid_o,
  input  logic                          m_axil_awready_i,

  output logic [`MEM_AXIL_DATA_W-1:0]   m_axil_wdata_o,
  output logic [`MEM_AXIL_DATA_W/8-1:0] m_axil_wstrb_o,
  output logic                          m_axil_wvalid_o,
  input  logic                          m_axil_wready_i,

  input  logic [1:0]                    m_axil_bresp_i,
  input  logic                          m_axil_bvalid_i,
  output logic                          m_axil_bready_o,

  output logic [`MEM_AXIL_ADDR_W-1:0]   m_axil_araddr_o,
  output logic [2:0]                    m_axil_arprot_o,
  output logic                          m_axil_arvalid_o,
  input  logic                          m_axil_arready_i,

  input  logic [`MEM_AXIL_DATA_W-1:0]   m_axil_rdata_i,
  input  logic [1:0]                    m_axil_rresp_i,
  input  logic                          m_axil_rvalid_i,
  output logic                          m_axil_rready_o
);

  typedef enum logic [2:0]
  {
    e_idle,
    e_write_addr_data,
    e_write_resp,
    e_read_addr,
    e_read_data,
    e_resp_hold
  } state_e;

  state_e                        state_q;
  logic                          awvalid_q;
  logic                          wvalid_q;
  logic                          arvalid_q;
  logic [`MEM_AXIL_ADDR_W-1:0]   addr_q;
  logic [`MEM_AXIL_DATA_W-1:0]   wdata_q;
  logic [`MEM_AXIL_DATA_W/8-1:0] wstrb_q;
  logic [`MEM_AXIL_DATA_W-1:0]   rdata_q;
  logic                          req_take;
  logic                          aw_fire;
  logic                          w_fire;

  assign req.ready = (state_q == e_idle);
  assign req_take  = req.valid & req.ready;

  assign aw_fire = awvalid_q & m_axil_awready_i;
  assign w_fire  = wvalid_q & m_axil_wready_i;

  // Address is shared by both directions, only one is ever valid
  assign m_axil_awaddr_o  = addr_q;
  assign m_axil_araddr_o  = addr_q;
  assign m_axil_awprot_o  = 3'b000;
  assign m_axil_arprot_o  = 3'b000;
  assign m_axil_awvalid_o = awvalid_q;
  assign m_axil_wdata_o   = wdata_q;
  assign m_axil_wstrb_o   = wstrb_q;
  assign m_axil_wvalid_o  = wvalid_q;
  assign m_axil_arvalid_o = arvalid_q;
  assign m_axil_bready_o  = (state_q == e_write_resp);
  assign m_axil_rready_o  = (state_q == e_read_data);

  assign rdata_o = rdata_q;
  assign rsp_v_o = (state_q == e_resp_hold);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= e_idle;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        e_idle:
        begin
          if (req_take && req.write)
          begin
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
            state_q   <= e_write_addr_data;
          end
          else if (req_take)
          begin
            arvalid_q <= 1'b1;
            state_q   <= e_read_addr;
          end
        end
        e_write_addr_data:
        begin
          // AW and W may complete in either order
          if (aw_fire)
            awvalid_q <= 1'b0;
          if (w_fire)
            wvalid_q <= 1'b0;
          if ((aw_fire || !awvalid_q) && (w_fire || !wvalid_q))
            state_q <= e_write_resp;
        end
        e_write_resp:
        begin
          if (m_axil_bvalid_i)
            state_q <= e_resp_hold;
        end
        e_read_addr:
        begin
          if (m_axil_arready_i)
          begin
            arvalid_q <= 1'b0;
            state_q   <= e_read_data;
          end
        end
        e_read_data:
        begin
          if (m_axil_rvalid_i)
            state_q <= e_resp_hold;
        end
        e_resp_hold:
        begin
          if (rsp_ready_i)
            state_q <= e_idle;
        end
        default:
          state_q <= e_idle;
      endcase
    end
  end

  // Request payload and read result
  always_ff @(posedge clk_i)
  begin
    if (req_take)
    begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
      wstrb_q <= req.wstrb;
    end
    if ((state_q == e_write_resp) && m_axil_bvalid_i)
      rdata_q <= '0;
    else if ((state_q == e_read_data) && m_axil_rvalid_i)
      rdata_q <= m_axil_rdata_i;
  end

endmodule

// File: design/resp_data_pack.sv
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module resp_data_pack
  import mem_axil_pkg::*;
(
  input  logic [`MEM_AXIL_DATA_W-1:0] word_i,
  input  logic [1:0]                  addr_lsb_i,
  input  mem_size_e                   size_i,
  output logic [`MEM_AXIL_DATA_W-1:0] data_o
);

  logic [`MEM_AXIL_DATA_W-1:0] shifted;

  // Addressed bytes moved down to lane 0
  assign shifted = word_i >> {addr_lsb_i, 3'b000};

  always_comb
  begin
    case (size_i)
      e_size_1:
        data_o = {(`MEM_AXIL_DATA_W/8){shifted[7:0]}};
      e_size_2:
        data_o = {(`MEM_AXIL_DATA_W/16){shifted[15:0]}};
      // Full word passes straight through
      default:
        data_o = shifted;
    endcase
  end

endmodule

// File: design/mem_axil_bridge.sv
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module mem_axil_bridge
  import mem_axil_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  mem_header_s                   mem_fwd_header_i,
  input  logic [`MEM_AXIL_DATA_W-1:0]   mem_fwd_data_i,
  input  logic                          mem_fwd_v_i,
  output logic                          mem_fwd_ready_o,

  output mem_header_s                   mem_rev_header_o,
  output logic [`MEM_AXIL_DATA_W-1:0]   mem_rev_data_o,
  output logic                          mem_rev_v_o,
  input  logic                          mem_rev_ready_i,

  output logic [`MEM_AXIL_ADDR_W-1:0]   m_axil_awaddr_o,
  output logic [2:0]                    m_axil_awprot_o,
  output logic                          m_axil_awvalid_o,
  input  logic                          m_axil_awready_i,

  output logic [`MEM_AXIL_DATA_W-1:0]   m_axil_wdata_o,
  output logic [`MEM_AXIL_DATA_W/8-1:0] m_axil_wstrb_o,
  output logic                          m_axil_wvalid_o,
  input  logic                          m_axil_wready_i,

  input  logic [1:0]                    m_axil_bresp_i,
  input  logic                          m_axil_bvalid_i,
  output logic                          m_axil_bready_o,

  output logic [`MEM_AXIL_ADDR_W-1:0]   m_axil_araddr_o,
  output logic [2:0]                    m_axil_arprot_o,
  output logic                          m_axil_arvalid_o,
  input  logic                          m_axil_arready_i,

  input  logic [`MEM_AXIL_DATA_W-1:0]   m_axil_rdata_i,
  input  logic [1:0]                    m_axil_rresp_i,
  input  logic                          m_axil_rvalid_i,
  output logic                          m_axil_rready_o
);

  axil_req_if req_bus ();

  logic                          hdr_ready;
  logic                          hdr_v;
  mem_header_s                   hdr_head;
  logic [`MEM_AXIL_DATA_W-1:0]   rsp_rdata;
  logic                          rsp_v;
  logic [`MEM_AXIL_DATA_W/8-1:0] base_strb;
  logic [`MEM_AXIL_DATA_W-1:0]   rep_wdata;

  // Forward accept needs both a header slot and an idle master
  assign mem_fwd_ready_o = hdr_ready & req_bus.ready;

  assign req_bus.valid = mem_fwd_v_i & hdr_ready;
  assign req_bus.addr  = mem_fwd_header_i.addr;
  assign req_bus.write = mem_fwd_header_i.msg_type inside {e_mem_wr, e_mem_uc_wr};
  assign req_bus.wstrb = base_strb << mem_fwd_header_i.addr[1:0];
  assign req_bus.wdata = rep_wdata;

  // Strobe pattern and low bytes replicated over every lane
  always_comb
  begin
    case (mem_fwd_header_i.size)
      e_size_1:
      begin
        base_strb = 4'h1;
        rep_wdata = {(`MEM_AXIL_DATA_W/8){mem_fwd_data_i[7:0]}};
      end
      e_size_2:
      begin
        base_strb = 4'h3;
        rep_wdata = {(`MEM_AXIL_DATA_W/16){mem_fwd_data_i[15:0]}};
      end
      default:
      begin
        base_strb = 4'hF;
        rep_wdata = mem_fwd_data_i;
      end
    endcase
  end

  two_entry_fifo
  #(
    .T (mem_header_s)
  )
  hdr_fifo
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (mem_fwd_header_i),
    .v_i     (mem_fwd_v_i & req_bus.ready),
    .ready_o (hdr_ready),
    .data_o  (hdr_head),
    .v_o     (hdr_v),
    .yumi_i  (mem_rev_v_o & mem_rev_ready_i)
  );

  axil_txn_master txn_master
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req              (req_bus.slave),
    .rdata_o          (rsp_rdata),
    .rsp_v_o          (rsp_v),
    .rsp_ready_i      (mem_rev_ready_i & hdr_v),
    .m_axil_awaddr_o  (m_axil_awaddr_o),
    .m_axil_awprot_o  (m_axil_awprot_o),
    .m_axil_awvalid_o (m_axil_awvalid_o),
    .m_axil_awready_i (m_axil_awready_i),
    .m_axil_wdata_o   (m_axil_wdata_o),
    .m_axil_wstrb_o   (m_axil_wstrb_o),
    .m_axil_wvalid_o  (m_axil_wvalid_o),
    .m_axil_wready_i  (m_axil_wready_i),
    .m_axil_bresp_i   (m_axil_bresp_i),
    .m_axil_bvalid_i  (m_axil_bvalid_i),
    .m_axil_bready_o  (m_axil_bready_o),
    .m_axil_araddr_o  (m_axil_araddr_o),
    .m_axil_arprot_o  (m_axil_arprot_o),
    .m_axil_arvalid_o (m_axil_arvalid_o),
    .m_axil_arready_i (m_axil_arready_i),
    .m_axil_rdata_i   (m_axil_rdata_i),
    .m_axil_rresp_i   (m_axil_rresp_i),
    .m_axil_rvalid_i  (m_axil_rvalid_i),
    .m_axil_rready_o  (m_axil_rready_o)
  );

  // Reverse message is queue head plus packed result
  assign mem_rev_v_o      = rsp_v & hdr_v;
  assign mem_rev_header_o = hdr_head;

  resp_data_pack rev_pack
  (
    .word_i     (rsp_rdata),
    .addr_lsb_i (hdr_head.addr[1:0]),
    .size_i     (hdr_head.size),
    .data_o     (mem_rev_data_o)
  );

endmodule

// File: tests/axil_mem_model.sv
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

// AXI-Lite slave memory, 256 words, ready and B timing gated by stall_i
module axil_mem_model
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Bit 0 AW, bit 1 W, bit 2 AR, bit 3 delays the write commit
  input  logic [3:0]                    stall_i,

  input  logic [`MEM_AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,
  input  logic [`MEM_AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`MEM_AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,
  output logic [1:0]                    s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,
  input  logic [`MEM_AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,
  output logic [`MEM_AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]                    s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i
);

  logic [31:0] mem [0:255];
  logic        aw_got;
  logic        w_got;
  logic [31:0] aw_addr;
  logic [31:0] w_data;
  logic [3:0]  w_strb;

  assign s_axil_awready_o = !aw_got && !stall_i[0];
  assign s_axil_wready_o  = !w_got && !stall_i[1];
  assign s_axil_arready_o = !s_axil_rvalid_o && !stall_i[2];
  assign s_axil_bresp_o   = 2'b00;
  assign s_axil_rresp_o   = 2'b00;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int k = 0; k < 4; k++)
      if (strb[k])
        merged[8*k +: 8] = new_word[8*k +: 8];
    return merged;
  endfunction

  always @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      aw_got          <= 1'b0;
      w_got           <= 1'b0;
      s_axil_bvalid_o <= 1'b0;
      s_axil_rvalid_o <= 1'b0;
    end
    else
    begin
      if (s_axil_awvalid_i && s_axil_awready_o)
      begin
        aw_got  <= 1'b1;
        aw_addr <= s_axil_awaddr_i;
      end
      if (s_axil_wvalid_i && s_axil_wready_o)
      begin
        w_got  <= 1'b1;
        w_data <= s_axil_wdata_i;
        w_strb <= s_axil_wstrb_i;
      end
      // Commit once both address and data have arrived
      if (aw_got && w_got && !stall_i[3])
      begin
        mem[aw_addr[9:2]] <= merge_bytes(mem[aw_addr[9:2]], w_data, w_strb);
        aw_got            <= 1'b0;
        w_got             <= 1'b0;
        s_axil_bvalid_o   <= 1'b1;
      end
      if (s_axil_bvalid_o && s_axil_bready_i)
        s_axil_bvalid_o <= 1'b0;
      if (s_axil_arvalid_i && s_axil_arready_o)
      begin
        s_axil_rvalid_o <= 1'b1;
        s_axil_rdata_o  <= mem[s_axil_araddr_i[9:2]];
      end
      if (s_axil_rvalid_o && s_axil_rready_i)
        s_axil_rvalid_o <= 1'b0;
    end
  end

endmodule

// File: tests/tb_mem_axil_bridge.sv
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module tb_mem_axil_bridge
  import mem_axil_pkg::*;
();

  localparam int          TIMEOUT   = 1000;
  localparam int          MEM_BYTES = 1024;
  localparam logic [31:0] SEED      = 32'd85408;

  logic        clk;
  logic        rst_n;
  mem_header_s fwd_header;
  logic [31:0] fwd_data;
  logic        fwd_v;
  logic        fwd_ready;
  mem_header_s rev_header;
  logic [31:0] rev_data;
  logic        rev_v;
  logic        rev_ready;

  logic [31:0] awaddr;
  logic [31:0] araddr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic [3:0]  wstrb;
  logic [2:0]  awprot;
  logic [2:0]  arprot;
  logic [1:0]  bresp;
  logic [1:0]  rresp;
  logic        awvalid;
  logic        awready;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic        rready;

  logic [3:0]  stall;
  logic        stall_en;
  logic [31:0] lfsr_q;
  logic [7:0]  ref_mem [0:MEM_BYTES-1];
  mem_header_s exp_hdr_q [$];
  logic [31:0] exp_data_q [$];

  mem_axil_bridge dut
  (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .mem_fwd_header_i (fwd_header),
    .mem_fwd_data_i   (fwd_data),
    .mem_fwd_v_i      (fwd_v),
    .mem_fwd_ready_o  (fwd_ready),
    .mem_rev_header_o (rev_header),
    .mem_rev_data_o   (rev_data),
    .mem_rev_v_o      (rev_v),
    .mem_rev_ready_i  (rev_ready),
    .m_axil_awaddr_o  (awaddr),
    .m_axil_awprot_o  (awprot),
    .m_axil_awvalid_o (awvalid),
    .m_axil_awready_i (awready),
    .m_axil_wdata_o   (wdata),
    .m_axil_wstrb_o   (wstrb),
    .m_axil_wvalid_o  (wvalid),
    .m_axil_wready_i  (wready),
    .m_axil_bresp_i   (bresp),
    .m_axil_bvalid_i  (bvalid),
    .m_axil_bready_o  (bready),
    .m_axil_araddr_o  (araddr),
    .m_axil_arprot_o  (arprot),
    .m_axil_arvalid_o (arvalid),
    .m_axil_arready_i (arready),
    .m_axil_rdata_i   (rdata),
    .m_axil_rresp_i   (rresp),
    .m_axil_rvalid_i  (rvalid),
    .m_axil_rready_o  (rready)
  );

  axil_mem_model axil_mem
  (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .stall_i          (stall),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  // Model stalls change off the +1 ns stimulus step
  always @(posedge clk)
  begin
    #2;
    if (stall_en)
      stall = lfsr_take(4);
    else
      stall = 4'h0;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Protection stays zero on every address beat
  always @(negedge clk)
  begin
    if (awvalid)
      check_eq("m_axil_awprot_o", awprot, 0);
    if (arvalid)
      check_eq("m_axil_arprot_o", arprot, 0);
  end

  // Same start pattern in the reference and the slave memory
  task automatic preload_memories();
    logic [9:0] a;
    logic [7:0] fill;
    for (int i = 0; i < MEM_BYTES; i++)
    begin
      a                                = i[9:0];
      fill                             = a[7:0] ^ {4{a[9:8]}};
      ref_mem[i]                       = fill;
      axil_mem.mem[i / 4][8*(i % 4) +: 8] = fill;
    end
  endtask

  function automatic mem_header_s make_hdr(mem_msg_type_e t, mem_size_e s, int addr, int tag);
    mem_header_s h;
    h.msg_type = t;
    h.size     = s;
    h.addr     = addr;
    h.tag      = tag[3:0];
    return h;
  endfunction

  // Reference update and expected reverse data for one message
  function automatic logic [31:0] expect_access(mem_header_s hdr, logic [31:0] data);
    int          nbytes;
    logic [9:0]  a;
    logic [31:0] word;
    nbytes = (hdr.size == e_size_1) ? 1 : (hdr.size == e_size_2) ? 2 : 4;
    a      = hdr.addr[9:0];
    word   = '0;
    if (hdr.msg_type == e_mem_wr || hdr.msg_type == e_mem_uc_wr)
    begin
      for (int j = 0; j < nbytes; j++)
        ref_mem[a + j] = data[8*j +: 8];
      return '0;
    end
    for (int j = 0; j < 4; j++)
      word[8*j +: 8] = ref_mem[a + (j % nbytes)];
    return word;
  endfunction

  task automatic send_fwd(input mem_header_s hdr, input logic [31:0] data);
    int   cycles;
    logic taken;
    cycles     = 0;
    taken      = 1'b0;
    fwd_header = hdr;
    fwd_data   = data;
    fwd_v      = 1'b1;
    while (!taken)
    begin
      @(negedge clk);
      taken = fwd_ready;
      @(posedge clk);
      #1;
      cycles++;
      if (!taken && cycles > TIMEOUT)
        fail_run("Timed out waiting for the bridge to accept a forward message");
    end
    fwd_v = 1'b0;
  endtask

  task automatic get_rev(output mem_header_s hdr, output logic [31:0] data);
    int   cycles;
    logic got;
    cycles    = 0;
    got       = 1'b0;
    rev_ready = 1'b1;
    while (!got)
    begin
      @(negedge clk);
      got  = rev_v;
      hdr  = rev_header;
      data = rev_data;
      @(posedge clk);
      #1;
      cycles++;
      if (!got && cycles > TIMEOUT)
        fail_run("Timed out waiting for a reverse message from the bridge");
    end
    rev_ready = 1'b0;
  endtask

  task automatic issue(input mem_header_s hdr, input logic [31:0] data);
    exp_hdr_q.push_back(hdr);
    exp_data_q.push_back(expect_access(hdr, data));
    send_fwd(hdr, data);
  endtask

  task automatic check_next_rev();
    mem_header_s hdr;
    logic [31:0] data;
    get_rev(hdr, data);
    if (exp_hdr_q.size() == 0)
      fail_run("Reverse message arrived with no forward message outstanding");
    check_eq("mem_rev_header_o", hdr, exp_hdr_q.pop_front());
    check_eq("mem_rev_data_o", data, exp_data_q.pop_front());
  endtask

  task automatic test_reset();
    int cycles;
    cycles = 0;
    @(negedge clk);
    check_eq("mem_rev_v_o", rev_v, 0);
    check_eq("m_axil_awvalid_o", awvalid, 0);
    check_eq("m_axil_wvalid_o", wvalid, 0);
    check_eq("m_axil_arvalid_o", arvalid, 0);
    check_eq("m_axil_bready_o", bready, 0);
    check_eq("m_axil_rready_o", rready, 0);
    while (!fwd_ready)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        fail_run("Forward ready never rose after reset");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_full_word();
    issue(make_hdr(e_mem_wr, e_size_4, 'h100, 1), lfsr_take(32));
    check_next_rev();
    issue(make_hdr(e_mem_rd, e_size_4, 'h100, 2), 32'h0);
    check_next_rev();
  endtask

  task automatic test_subword();
    for (int off = 0; off < 4; off++)
    begin
      issue(make_hdr(e_mem_uc_wr, e_size_1, 'h200 + off, off), lfsr_take(32));
      check_next_rev();
    end
    issue(make_hdr(e_mem_wr, e_size_2, 'h240, 4), lfsr_take(32));
    check_next_rev();
    issue(make_hdr(e_mem_wr, e_size_2, 'h242, 5), lfsr_take(32));
    check_next_rev();
    issue(make_hdr(e_mem_rd, e_size_4, 'h200, 6), 32'h0);
    check_next_rev();
    issue(make_hdr(e_mem_uc_rd, e_size_4, 'h240, 7), 32'h0);
    check_next_rev();
    // Byte read comes back replicated on all four lanes
    issue(make_hdr(e_mem_rd, e_size_1, 'h203, 8), 32'h0);
    check_next_rev();
  endtask

  task automatic test_back_pressure();
    int extra;
    extra = 0;
    issue(make_hdr(e_mem_uc_wr, e_size_4, 'h300, 9), lfsr_take(32));
    fork
      // Two more messages offered while the first response is held
      begin
        issue(make_hdr(e_mem_rd, e_size_4, 'h300, 10), 32'h0);
        issue(make_hdr(e_mem_wr, e_size_2, 'h302, 11), lfsr_take(32));
      end
      begin
        repeat (30)
        begin
          @(negedge clk);
          if (fwd_v && fwd_ready)
            extra++;
        end
        check_eq("mem_fwd_ready_o", fwd_ready, 0);
        check_eq("mem_rev_v_o", rev_v, 1);
        check_eq("forward accepts under back-pressure <= 1", extra <= 1, 1);
        @(posedge clk);
        #1;
        check_next_rev();
        check_next_rev();
        check_next_rev();
      end
    join
  endtask

  task automatic test_random();
    stall_en = 1'b1;
    fork
      for (int n = 0; n < 200; n++)
      begin
        mem_msg_type_e t;
        mem_size_e     s;
        logic [1:0]    off;
        t   = mem_msg_type_e'(lfsr_take(2));
        s   = mem_size_e'(lfsr_take(2) % 3);
        off = lfsr_take(2);
        off = (s == e_size_1) ? off : (s == e_size_2) ? {off[1], 1'b0} : 2'b00;
        issue(make_hdr(t, s, {lfsr_take(8), off}, lfsr_take(4)), lfsr_take(32));
      end
      repeat (200) check_next_rev();
    join
    stall_en = 1'b0;
    // Nothing further may come back once every message is answered
    repeat (5)
    begin
      @(negedge clk);
      check_eq("mem_rev_v_o", rev_v, 0);
    end
  endtask

  initial
  begin
    rst_n      = 1'b0;
    fwd_header = '0;
    fwd_data   = '0;
    fwd_v      = 1'b0;
    rev_ready  = 1'b0;
    stall      = 4'h0;
    stall_en   = 1'b0;
    lfsr_q     = SEED;
    preload_memories();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_full_word();
    test_subword();
    test_back_pressure();
    test_random();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: mem_axil_bridge.f
+incdir+design
design/mem_axil_pkg.sv
design/axil_req_if.sv
design/two_entry_fifo.sv
design/axil_txn_master.sv
design/resp_data_pack.sv
design/mem_axil_bridge.sv
tests/axil_mem_model.sv
tests/tb_mem_axil_bridge.sv

// File: Bender.yml
package:
  name: mem_axil_bridge

sources:
  - include_dirs:
      - design
    files:
      - design/mem_axil_pkg.sv
      - design/axil_req_if.sv
      - design/two_entry_fifo.sv
      - design/axil_txn_master.sv
      - design/resp_data_pack.sv
      - design/mem_axil_bridge.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/axil_mem_model.sv
      - tests/tb_mem_axil_bridge.sv
